/* files.f */
+incdir+hdl
hdl/oadc_pkg.sv
hdl/oadc_cfg_if.sv
hdl/adc_reg_bank.sv
hdl/heartbeat_leds.sv
hdl/extclk_monitor.sv
hdl/adc_level_trigger.sv
hdl/openadc_core.sv
verification/tb_openadc_core.sv

/* hdl/adc_level_trigger.sv */
`timescale 1ns/1ps
`include "oadc_settings.svh"

module adc_level_trigger (
   input  logic              clk_usb,
   input  logic              reset,
   input  oadc_pkg::sample_t adc_data_i,
   output logic              trigger_adc_o,
   oadc_cfg_if.trigger       cfg
);
   import oadc_pkg::*;

   trig_state_e state;
   sample_t     test_cnt;
   sample_t     sample_d1;
   sample_t     sample_d2;
   logic        level_hit;

   always_ff @(posedge clk_usb) begin
      if (reset)
         test_cnt <= '0;
      else
         test_cnt <= test_cnt + 1'b1;
   end

   // two-stage sample delay
   always_ff @(posedge clk_usb) begin
      sample_d1 <= cfg.source_adc ? adc_data_i : test_cnt;
      sample_d2 <= sample_d1;
   end

   // msb of level picks above or below
   assign level_hit = cfg.trig_level[`OADC_SAMPLE_W-1] ? (sample_d2 > cfg.trig_level)
                                                       : (sample_d2 < cfg.trig_level);

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         state         <= TRIG_IDLE;
         trigger_adc_o <= 1'b0;
      end else begin
         trigger_adc_o <= 1'b0;
         case (state)
            TRIG_IDLE: begin
               if (cfg.arm_pulse)
                  state <= TRIG_ARMED;
            end
            TRIG_ARMED: begin
               if (level_hit) begin
                  state         <= TRIG_IDLE; // single shot
                  trigger_adc_o <= 1'b1;
               end
            end
            default: state <= TRIG_IDLE;
         endcase
      end
   end

   assign cfg.armed = (state == TRIG_ARMED);

   a_trig_one_cycle: assert property (@(posedge clk_usb) disable iff (reset)
      trigger_adc_o |=> !trigger_adc_o);

   a_trig_from_armed: assert property (@(posedge clk_usb) disable iff (reset)
      trigger_adc_o |-> ($past(state) == TRIG_ARMED));

endmodule

/* hdl/adc_reg_bank.sv */
`timescale 1ns/1ps

module adc_reg_bank (
   input  logic       clk_usb,
   input  logic       reset,
   input  logic [7:0] reg_address_i,
   input  logic [7:0] reg_datai_i,
   input  logic       reg_write_i,
   input  logic       reg_read_i,
   input  logic       pll_status_i,
   output logic [7:0] reg_datao_o,
   output logic       amp_gain_o,
   oadc_cfg_if.regs   cfg
);
   import oadc_pkg::*;

   logic [7:0] settings_q; // bit 0 reads back as zero
   logic [7:0] gain_q;
   logic [7:0] trig_lo_q;
   logic [7:0] trig_hi_q;
   logic [7:0] limit_q;
   logic [7:0] status_byte;
   logic [7:0] read_mux;
   logic [8:0] pwm_acc;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         settings_q    <= 8'h00;
         gain_q        <= 8'h00;
         trig_lo_q     <= 8'h00;
         trig_hi_q     <= 8'h00;
         limit_q       <= 8'h00;
         cfg.arm_pulse <= 1'b0;
      end else begin
         cfg.arm_pulse <= 1'b0;
         if (reg_write_i) begin
            case (reg_address_i)
               REG_SETTINGS: begin
                  settings_q    <= {reg_datai_i[7:1], 1'b0};
                  cfg.arm_pulse <= reg_datai_i[0]; // strobe only
               end
               REG_GAIN:         gain_q    <= reg_datai_i;
               REG_TRIG_LO:      trig_lo_q <= reg_datai_i;
               REG_TRIG_HI:      trig_hi_q <= reg_datai_i;
               REG_EXTCLK_LIMIT: limit_q   <= reg_datai_i;
               default: ;
            endcase
         end
      end
   end

   assign cfg.source_adc      = settings_q[1];
   assign cfg.led_mode        = led_mode_e'(settings_q[3:2]);
   assign cfg.monitor_disable = settings_q[4];
   assign cfg.trig_level      = sample_t'({trig_hi_q, trig_lo_q}); // upper nibble dropped
   assign cfg.extclk_limit    = limit_q;

   assign status_byte = {3'b000, pll_status_i, 1'b0, cfg.extclk_change, 1'b0, cfg.armed};

   always_comb begin
      case (reg_address_i)
         REG_SETTINGS:     read_mux = settings_q;
         REG_STATUS:       read_mux = status_byte;
         REG_GAIN:         read_mux = gain_q;
         REG_TRIG_LO:      read_mux = trig_lo_q;
         REG_TRIG_HI:      read_mux = trig_hi_q;
         REG_EXTCLK_LIMIT: read_mux = limit_q;
         REG_FREQ_LO:      read_mux = cfg.extclk_freq[7:0];
         REG_FREQ_HI:      read_mux = cfg.extclk_freq[15:8];
         default:          read_mux = 8'h00;
      endcase
   end

   always_ff @(posedge clk_usb) begin
      if (reset)
         reg_datao_o <= 8'h00;
      else if (reg_read_i)
         reg_datao_o <= read_mux; // held until next read
   end

   // carry out of the 8-bit sum is the pwm bit
   always_ff @(posedge clk_usb) begin
      if (reset)
         pwm_acc <= 9'd0;
      else
         pwm_acc <= {1'b0, pwm_acc[7:0]} + {1'b0, gain_q};
   end

   assign amp_gain_o = pwm_acc[8];

   a_no_rd_wr: assert property (@(posedge clk_usb) disable iff (reset)
      !(reg_write_i && reg_read_i))
      else $error("register read and write strobes high together");

endmodule

/* hdl/extclk_monitor.sv */
`timescale 1ns/1ps

module extclk_monitor (
   input  logic        clk_usb,
   input  logic        reset,
   input  logic        extclk_i,
   input  logic        window_pulse_i,
   oadc_cfg_if.monitor cfg
);
   import oadc_pkg::*;

   logic [1:0] sync_q;
   logic       sync_d;
   logic       rise;
   freq_t      edge_cnt;
   freq_t      new_count;
   freq_t      delta;

   // extclk_i is asynchronous to clk_usb
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         sync_q <= 2'b00;
         sync_d <= 1'b0;
      end else begin
         sync_q <= {sync_q[0], extclk_i};
         sync_d <= sync_q[1];
      end
   end

   assign rise = sync_q[1] & ~sync_d;

   // include an edge that lands on the pulse cycle
   assign new_count = edge_cnt + freq_t'(rise);

   assign delta = (new_count > cfg.extclk_freq) ? new_count - cfg.extclk_freq
                                                : cfg.extclk_freq - new_count;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         edge_cnt        <= '0;
         cfg.extclk_freq <= '0;
      end else if (window_pulse_i) begin
         edge_cnt        <= '0;
         cfg.extclk_freq <= new_count;
      end else begin
         edge_cnt <= new_count;
      end
   end

   // sticky until the monitor is disabled
   always_ff @(posedge clk_usb) begin
      if (reset)
         cfg.extclk_change <= 1'b0;
      else if (cfg.monitor_disable)
         cfg.extclk_change <= 1'b0;
      else if (window_pulse_i && (cfg.extclk_freq != '0) &&
               (delta > freq_t'(cfg.extclk_limit)))
         cfg.extclk_change <= 1'b1;
   end

endmodule

/* hdl/heartbeat_leds.sv */
`timescale 1ns/1ps
`include "oadc_settings.svh"

module heartbeat_leds (
   input  logic     clk_usb,
   input  logic     reset,
   output logic     window_pulse_o,
   output logic     led_armed_o,
   output logic     led_capture_o,
   oadc_cfg_if.leds cfg
);
   import oadc_pkg::*;

   logic [`OADC_TIMER_W-1:0] timer_q;
   logic                     flash_q;
   logic                     heartbeat;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         timer_q        <= '0;
         window_pulse_o <= 1'b0;
         flash_q        <= 1'b0;
      end else begin
         timer_q        <= timer_q + 1'b1;
         window_pulse_o <= &timer_q[`OADC_WINDOW_BITS-1:0]; // once per window
         if (timer_q[`OADC_HEARTBEAT_BIT])
            flash_q <= ~timer_q[`OADC_FLASH_BIT]; // burst of fast blinks
      end
   end

   assign heartbeat = timer_q[`OADC_HEARTBEAT_BIT];

   // change flag overrides the selected mode
   always_comb begin
      if (cfg.extclk_change) begin
         led_armed_o   = flash_q;
         led_capture_o = flash_q;
      end else begin
         case (cfg.led_mode)
            LED_HEARTBEAT: begin
               led_armed_o   = heartbeat;
               led_capture_o = ~heartbeat;
            end
            LED_EXTCLK: begin
               led_armed_o   = heartbeat;
               led_capture_o = cfg.extclk_freq[0];
            end
            LED_CHANGE: begin
               led_armed_o   = heartbeat;
               led_capture_o = cfg.extclk_change;
            end
            default: begin
               led_armed_o   = cfg.armed;
               led_capture_o = cfg.armed; // trigger pending
            end
         endcase
      end
   end

   a_window_one_cycle: assert property (@(posedge clk_usb) disable iff (reset)
      window_pulse_o |=> !window_pulse_o);

endmodule

/* hdl/oadc_cfg_if.sv */
`timescale 1ns/1ps

interface oadc_cfg_if;
   import oadc_pkg::*;

   // settings from the register bank
   logic      arm_pulse;
   logic      source_adc;      // 1 = adc, 0 = test counter
   led_mode_e led_mode;
   sample_t   trig_level;
   logic      monitor_disable;
   logic [7:0] extclk_limit;

   // status back to the register bank
   logic      armed;
   logic      extclk_change;
   freq_t     extclk_freq;

   modport regs (
      output arm_pulse, source_adc, led_mode, trig_level, monitor_disable, extclk_limit,
      input  armed, extclk_change, extclk_freq
   );

   modport trigger (input arm_pulse, source_adc, trig_level, output armed);

   modport monitor (
      input  monitor_disable, extclk_limit,
      output extclk_change, extclk_freq
   );

   modport leds (input armed, extclk_change, led_mode, extclk_freq);

endinterface

/* hdl/oadc_pkg.sv */
`include "oadc_settings.svh"

package oadc_pkg;

   typedef logic [`OADC_SAMPLE_W-1:0] sample_t;
   typedef logic [`OADC_FREQ_W-1:0] freq_t;

   // byte-wide register map
   typedef enum logic [7:0] {
      REG_SETTINGS     = 8'd1,
      REG_STATUS       = 8'd2, // read only
      REG_GAIN         = 8'd4,
      REG_TRIG_LO      = 8'd5,
      REG_TRIG_HI      = 8'd6,
      REG_EXTCLK_LIMIT = 8'd7,
      REG_FREQ_LO      = 8'd8, // read only
      REG_FREQ_HI      = 8'd9  // read only
   } reg_addr_e;

   typedef enum logic [1:0] {
      LED_STATUS    = 2'd0,
      LED_HEARTBEAT = 2'd1,
      LED_EXTCLK    = 2'd2,
      LED_CHANGE    = 2'd3
   } led_mode_e;

   typedef enum logic {
      TRIG_IDLE  = 1'b0,
      TRIG_ARMED = 1'b1
   } trig_state_e;

endpackage

/* hdl/oadc_settings.svh */
`ifndef OADC_SETTINGS_SVH
`define OADC_SETTINGS_SVH

// adc sample width
`define OADC_SAMPLE_W 12

// target clock edges per window
`define OADC_FREQ_W 16

// window is 2**OADC_WINDOW_BITS clk_usb cycles
`define OADC_WINDOW_BITS 8

// heartbeat timer
`define OADC_TIMER_W 12
`define OADC_HEARTBEAT_BIT 5
`define OADC_FLASH_BIT 3

`endif

/* hdl/openadc_core.sv */
`timescale 1ns/1ps

module openadc_core (
   input  logic              clk_usb,
   input  logic              reset,
   input  oadc_pkg::sample_t adc_data_i,
   input  logic              extclk_i,
   input  logic              pll_status_i,
   input  logic [7:0]        reg_address_i,
   input  logic [7:0]        reg_datai_i,
   input  logic              reg_write_i,
   input  logic              reg_read_i,
   output logic [7:0]        reg_datao_o,
   output logic              trigger_adc_o,
   output logic              amp_gain_o,
   output logic              led_armed_o,
   output logic              led_capture_o
);

   logic window_pulse; // heartbeat timer to monitor

   oadc_cfg_if i_cfg ();

   adc_reg_bank i_adc_reg_bank (
      .clk_usb       (clk_usb),
      .reset         (reset),
      .reg_address_i (reg_address_i),
      .reg_datai_i   (reg_datai_i),
      .reg_write_i   (reg_write_i),
      .reg_read_i    (reg_read_i),
      .pll_status_i  (pll_status_i),
      .reg_datao_o   (reg_datao_o),
      .amp_gain_o    (amp_gain_o),
      .cfg           (i_cfg.regs)
   );

   adc_level_trigger i_adc_level_trigger (
      .clk_usb       (clk_usb),
      .reset         (reset),
      .adc_data_i    (adc_data_i),
      .trigger_adc_o (trigger_adc_o),
      .cfg           (i_cfg.trigger)
   );

   extclk_monitor i_extclk_monitor (
      .clk_usb        (clk_usb),
      .reset          (reset),
      .extclk_i       (extclk_i),
      .window_pulse_i (window_pulse),
      .cfg            (i_cfg.monitor)
   );

   heartbeat_leds i_heartbeat_leds (
      .clk_usb        (clk_usb),
      .reset          (reset),
      .window_pulse_o (window_pulse),
      .led_armed_o    (led_armed_o),
      .led_capture_o  (led_capture_o),
      .cfg            (i_cfg.leds)
   );

endmodule

/* verification/tb_openadc_core.sv */
`timescale 1ns/1ps
`include "oadc_settings.svh"

module tb_openadc_core;
   import oadc_pkg::*;

   typedef enum int {
      KIND_REGRW, KIND_STATUS, KIND_TRIG, KIND_COUNTER,
      KIND_FREQ, KIND_CHANGE, KIND_GAIN, KIND_LED
   } test_kind_e;

   typedef struct {
      test_kind_e  kind;
      logic [11:0] a;   // address, level, limit or gain
      logic [11:0] b;   // data, pll bit, adc base or extclk half-period
      logic [15:0] exp;
   } row_t;

   localparam int NUM_ROWS = 20;
   localparam int WINDOW   = 1 << `OADC_WINDOW_BITS;

   logic       clk_usb;
   logic       reset;
   sample_t    adc_data_i;
   logic       extclk_i;
   logic       pll_status_i;
   logic [7:0] reg_address_i;
   logic [7:0] reg_datai_i;
   logic       reg_write_i;
   logic       reg_read_i;
   logic [7:0] reg_datao_o;
   logic       trigger_adc_o;
   logic       amp_gain_o;
   logic       led_armed_o;
   logic       led_capture_o;

   int ext_half; // half-period in clk_usb cycles where 0 stops extclk
   int ext_cnt;
   int err_count;
   int fail_count;

   row_t rows [NUM_ROWS] = '{
      '{KIND_REGRW,   12'h004, 12'h05A, 16'h005A},
      '{KIND_REGRW,   12'h005, 12'h034, 16'h0034},
      '{KIND_REGRW,   12'h006, 12'h008, 16'h0008},
      '{KIND_REGRW,   12'h007, 12'h010, 16'h0010},
      '{KIND_STATUS,  12'h000, 12'h001, 16'h0010},
      '{KIND_STATUS,  12'h000, 12'h000, 16'h0000},
      '{KIND_TRIG,    12'h900, 12'hA00, 16'h0001}, // above level
      '{KIND_TRIG,    12'h400, 12'h100, 16'h0001}, // below level
      '{KIND_COUNTER, 12'h010, 12'h000, 16'h0001},
      '{KIND_FREQ,    12'h000, 12'h004, 16'd32},
      '{KIND_FREQ,    12'h000, 12'h002, 16'd64},
      '{KIND_CHANGE,  12'h008, 12'h002, 16'h0001},
      '{KIND_GAIN,    12'h000, 12'h000, 16'h0000},
      '{KIND_GAIN,    12'h001, 12'h000, 16'h0001},
      '{KIND_GAIN,    12'h080, 12'h000, 16'h0080},
      '{KIND_GAIN,    12'h0C3, 12'h000, 16'h00C3},
      '{KIND_GAIN,    12'h0FF, 12'h000, 16'h00FF},
      '{KIND_LED,     12'h000, 12'h000, 16'h0000},
      '{KIND_TRIG,    12'hFFF, 12'h000, 16'h0000}, // compare can never pass
      '{KIND_LED,     12'h000, 12'h000, 16'h0001}  // still armed
   };

   openadc_core i_openadc_core (.*);

   always #5 clk_usb = ~clk_usb;

   // target clock toggles on the falling edge like every other input
   always @(negedge clk_usb) begin
      if (ext_half == 0) begin
         ext_cnt = 0;
      end else if (ext_cnt >= ext_half - 1) begin
         ext_cnt  = 0;
         extclk_i = ~extclk_i;
      end else begin
         ext_cnt = ext_cnt + 1;
      end
   end

   task automatic write_reg(input reg_addr_e addr, input logic [7:0] data);
      @(negedge clk_usb);
      reg_address_i = addr;
      reg_datai_i   = data;
      reg_write_i   = 1'b1;
      @(negedge clk_usb);
      reg_write_i   = 1'b0;
   endtask

   task automatic read_reg(input reg_addr_e addr, output logic [7:0] data);
      @(negedge clk_usb);
      reg_address_i = addr;
      reg_read_i    = 1'b1;
      @(negedge clk_usb);
      reg_read_i    = 1'b0;
      data          = reg_datao_o;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) @(negedge clk_usb);
   endtask

   task automatic wait_trigger(input int limit, output logic seen);
      int i;
      seen = 1'b0;
      for (i = 0; i < limit && !seen; i++) begin
         @(negedge clk_usb);
         if (trigger_adc_o)
            seen = 1'b1;
      end
   endtask

   task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp) begin
         $display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
         err_count++;
      end
   endtask

   task automatic check_freq(input string name, input freq_t got, input freq_t exp);
      if (got !== exp) begin
         $display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
         err_count++;
      end
   endtask

   task automatic check_pulse(input string name, input logic seen, input logic exp);
      if (seen !== exp) begin
         if (exp)
            $display("no pulse on %s before the timeout", name);
         else
            $display("unexpected pulse on %s", name);
         err_count++;
      end
   endtask

   task automatic run_row(input row_t r);
      logic [7:0] rd;
      logic [7:0] hi;
      logic       seen;
      int         cnt;
      case (r.kind)
         KIND_REGRW: begin
            write_reg(reg_addr_e'(r.a[7:0]), r.b[7:0]);
            read_reg(reg_addr_e'(r.a[7:0]), rd);
            check_byte("reg_datao_o", rd, r.exp[7:0]);
         end
         KIND_STATUS: begin
            pll_status_i = r.b[0];
            read_reg(REG_STATUS, rd);
            check_byte("reg_datao_o", rd, r.exp[7:0]);
         end
         KIND_TRIG, KIND_COUNTER: begin
            write_reg(REG_TRIG_LO, r.a[7:0]);
            write_reg(REG_TRIG_HI, {4'h0, r.a[11:8]});
            adc_data_i = r.b + sample_t'($urandom % 256);
            // arm with the adc source for level rows and the test counter otherwise
            write_reg(REG_SETTINGS, (r.kind == KIND_TRIG) ? 8'h03 : 8'h01);
            wait_trigger((r.kind == KIND_TRIG) ? 64 : 4096, seen);
            check_pulse("trigger_adc_o", seen, r.exp[0]);
            if (seen) begin
               read_reg(REG_STATUS, rd);
               check_byte("armed", rd & 8'h01, 8'h00);
               wait_trigger(32, seen); // single shot
               check_pulse("trigger_adc_o", seen, 1'b0);
            end
         end
         KIND_FREQ: begin
            ext_half = r.b;
            idle_cycles(2 * WINDOW + 8);
            read_reg(REG_FREQ_LO, rd);
            read_reg(REG_FREQ_HI, hi);
            check_freq("extclk_freq", {hi, rd}, freq_t'(r.exp));
         end
         KIND_CHANGE: begin
            write_reg(REG_EXTCLK_LIMIT, r.a[7:0]);
            ext_half = 4;
            write_reg(REG_SETTINGS, 8'h12); // monitor off while period settles
            idle_cycles(2 * WINDOW + 8);
            write_reg(REG_SETTINGS, 8'h06); // heartbeat mode keeps the leds apart
            ext_half = r.b;
            idle_cycles(2 * WINDOW + 8);
            read_reg(REG_STATUS, rd);
            check_byte("extclk_change", rd & 8'h04, r.exp[0] ? 8'h04 : 8'h00);
            cnt = 0;
            repeat (64) begin
               @(negedge clk_usb);
               if (led_armed_o !== led_capture_o)
                  cnt++;
            end
            check_byte("led_capture_o mismatches", cnt[7:0], 8'h00);
            write_reg(REG_SETTINGS, 8'h12);
            read_reg(REG_STATUS, rd);
            check_byte("extclk_change", rd & 8'h04, 8'h00);
            write_reg(REG_SETTINGS, 8'h02);
         end
         KIND_GAIN: begin
            write_reg(REG_GAIN, r.a[7:0]);
            cnt = 0;
            repeat (256) begin
               @(negedge clk_usb);
               if (amp_gain_o)
                  cnt++;
            end
            check_byte("amp_gain_o high cycles", cnt[7:0], r.exp[7:0]);
         end
         KIND_LED: begin
            read_reg(REG_STATUS, rd);
            check_byte("armed", rd & 8'h01, r.exp[7:0]);
            check_byte("led_armed_o", {7'b0, led_armed_o}, {7'b0, r.exp[0]});
            check_byte("led_capture_o", {7'b0, led_capture_o}, {7'b0, r.exp[0]});
         end
         default: ;
      endcase
   endtask

   initial begin
      int i;
      int errs_before;
      void'($urandom(32'h2320));
      clk_usb       = 1'b0;
      reset         = 1'b1;
      adc_data_i    = '0;
      extclk_i      = 1'b0;
      pll_status_i  = 1'b0;
      reg_address_i = 8'h00;
      reg_datai_i   = 8'h00;
      reg_write_i   = 1'b0;
      reg_read_i    = 1'b0;
      ext_half      = 0;
      ext_cnt       = 0;
      err_count     = 0;
      fail_count    = 0;
      repeat (10) @(negedge clk_usb);
      reset = 1'b0;

      for (i = 0; i < NUM_ROWS; i++) begin
         errs_before = err_count;
         run_row(rows[i]);
         if (err_count == errs_before) begin
            $display("test %0d %s: ok", i, rows[i].kind.name());
         end else begin
            fail_count++;
            $display("test %0d %s: FAILED", i, rows[i].kind.name());
         end
      end

      $display("%0d tests, %0d failed, %0d errors", NUM_ROWS, fail_count, err_count);
      if (fail_count == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule
